// ==== all.f ====
+incdir+dv
logic/ex_pkg.sv
logic/reg_file.sv
logic/csr_unit.sv
logic/exec_stage.sv
logic/ex_top.sv
dv/ex_asserts.sv
dv/ex_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module ex_tb -o ex_sim
./obj_dir/ex_sim 2>&1 | tee sim.log
if grep -q "Test failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"

// ==== dv/ex_tb_model.svh ====
// Execute stage reference model

xlen_t     m_regs [32];
xlen_t     m_mtvec;
xlen_t     m_mepc;
xlen_t     m_mcause;
xlen_t     m_mscratch;
logic      exp_fetch_req;
xlen_t     exp_fetch_addr;
logic      exp_wb_we;
reg_addr_t exp_wb_rd;
xlen_t     exp_wb_data;
xlen_t     exp_lsu_addr;
xlen_t     exp_lsu_wdata;

function automatic xlen_t pick_src(src_sel_t sel, xlen_t r, xlen_t imm, xlen_t pc);
  case (sel)
    SRC_REG: return r;
    SRC_IMM: return imm;
    SRC_PC:  return pc;
    default: return '0;
  endcase
endfunction

function automatic xlen_t alu_model(alu_f3_t f3, logic alt, xlen_t a, xlen_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(alu_f3_t f3, xlen_t a, xlen_t b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_mtvec        = TB_MTVEC;
  m_mepc         = '0;
  m_mcause       = '0;
  m_mscratch     = '0;
  exp_fetch_req  = 1'b0;
  exp_fetch_addr = '0;
  exp_wb_we      = 1'b0;
  exp_wb_rd      = '0;
  exp_wb_data    = '0;
endtask

// Advance the model by one clock edge
task automatic model_step(input logic acc);
  xlen_t r1;
  xlen_t r2;
  xlen_t op1;
  xlen_t op2;
  xlen_t alu;
  xlen_t tgt;
  xlen_t old;
  xlen_t nv;
  logic  taken;
  logic  trap;
  logic  hit;
  if (!acc) begin
    exp_fetch_req = 1'b0;
    if (!lsu_bp_i) begin
      exp_wb_we = 1'b0;
    end
    return;
  end
  r1  = m_regs[id_rs1_addr_i];
  r2  = m_regs[id_rs2_addr_i];
  op1 = pick_src(id_src1_sel_i, r1, id_imm_i, id_pc_i);
  op2 = pick_src(id_src2_sel_i, r2, id_imm_i, id_pc_i);
  alu = alu_model(id_f3_i, id_alt_i, op1, op2);
  exp_lsu_addr  = alu;
  exp_lsu_wdata = r2;
  // Wrong-path instruction behind a redirect
  if (exp_fetch_req) begin
    exp_fetch_req = 1'b0;
    exp_wb_we     = 1'b0;
    return;
  end
  taken = 1'b0;
  tgt   = '0;
  if (id_jump_i) begin
    taken = 1'b1;
    tgt   = (op1 + id_imm_i) & 32'hFFFF_FFFE;
  end else if (id_branch_i) begin
    taken = branch_taken(id_f3_i, r1, r2);
    tgt   = id_pc_i + id_imm_i;
  end
  trap = id_ecall_i || (taken && (tgt[1:0] != 2'b00));
  hit  = 1'b1;
  case (id_csr_addr_i)
    CSR_MTVEC:    old = m_mtvec;
    CSR_MEPC:     old = m_mepc;
    CSR_MCAUSE:   old = m_mcause;
    CSR_MSCRATCH: old = m_mscratch;
    default: begin
      old = '0;
      hit = 1'b0;
    end
  endcase
  exp_fetch_req = trap || id_mret_i || taken;
  exp_fetch_addr = trap ? m_mtvec : (id_mret_i ? m_mepc : tgt);
  if (trap) begin
    m_mepc   = id_pc_i;
    m_mcause = id_ecall_i ? 32'd11 : 32'd0;
  end
  case (id_csr_op_i)
    CSR_RW:  nv = r1;
    CSR_RS:  nv = old | r1;
    CSR_RC:  nv = old & ~r1;
    default: nv = old;
  endcase
  if (hit && (id_csr_op_i != CSR_NONE)) begin
    case (id_csr_addr_i)
      CSR_MTVEC:  m_mtvec = nv;
      CSR_MEPC:   m_mepc = nv;
      CSR_MCAUSE: m_mcause = nv;
      default:    m_mscratch = nv;
    endcase
  end
  exp_wb_we   = id_we_rd_i && (id_rd_addr_i != '0) && !trap;
  exp_wb_rd   = id_rd_addr_i;
  exp_wb_data = id_jump_i ? id_pc_i + 32'd4 : ((id_csr_op_i != CSR_NONE) ? old : alu);
  if (exp_wb_we) begin
    m_regs[id_rd_addr_i] = exp_wb_data;
  end
endtask

// ==== dv/ex_tb.sv ====
// Execute stage testbench
`timescale 1ns/1ns

module ex_tb;
  import ex_pkg::*;

  localparam int          PERIOD   = 20;
  localparam int          N_INSTR  = 1500;
  localparam int          RST_CYC  = 8;
  localparam int unsigned SEED     = 98445;
  localparam xlen_t       TB_MTVEC = 32'h8000_0100;

  logic      clk;
  logic      rst_i;
  logic      id_valid_i;
  logic      id_ready_o;
  xlen_t     id_pc_i;
  xlen_t     id_imm_i;
  reg_addr_t id_rs1_addr_i;
  reg_addr_t id_rs2_addr_i;
  reg_addr_t id_rd_addr_i;
  logic      id_we_rd_i;
  src_sel_t  id_src1_sel_i;
  src_sel_t  id_src2_sel_i;
  alu_f3_t   id_f3_i;
  logic      id_alt_i;
  logic      id_branch_i;
  logic      id_jump_i;
  lsu_op_t   id_lsu_op_i;
  csr_op_t   id_csr_op_i;
  csr_addr_t id_csr_addr_i;
  logic      id_ecall_i;
  logic      id_mret_i;
  logic      lsu_bp_i;
  lsu_op_t   lsu_op_o;
  xlen_t     lsu_addr_o;
  xlen_t     lsu_wdata_o;
  logic      fetch_req_o;
  xlen_t     fetch_addr_o;
  logic      wb_we_o;
  reg_addr_t wb_rd_o;
  xlen_t     wb_data_o;

  ex_top #(.MTVEC_RESET(TB_MTVEC)) uut (.*);

  bind exec_stage ex_asserts u_asserts (
    .clk         (clk),
    .rst_i       (rst_i),
    .lsu_bp_i    (lsu_bp_i),
    .fetch_req_o (fetch_req_o),
    .wb_we_o     (wb_we_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o)
  );

  `include "ex_tb_model.svh"

  always #(PERIOD / 2) clk = ~clk;

  task automatic compare_value(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("ERROR %s expected 0x%08h actual 0x%08h", name, exp, act);
      $display("Test failed");
      $fatal(1, "mismatch");
    end
  endtask

  // Small word offset that is sometimes off by two
  function automatic xlen_t target_offset();
    xlen_t off;
    off = xlen_t'($urandom % 64) << 2;
    if ($urandom % 4 == 0) begin
      off = off + 32'd2;
    end
    return ($urandom % 2) ? off : -off;
  endfunction

  task automatic gen_instr();
    int unsigned k;
    k = $urandom % 100;
    id_pc_i       = $urandom & 32'hFFFF_FFFC;
    id_imm_i      = ($urandom % 2) ? $urandom : xlen_t'($urandom % 64);
    id_rs1_addr_i = reg_addr_t'($urandom % 6);
    id_rs2_addr_i = reg_addr_t'($urandom % 6);
    id_rd_addr_i  = reg_addr_t'($urandom % 6);
    id_we_rd_i    = 1'b1;
    id_src1_sel_i = ($urandom % 8 == 0) ? src_sel_t'($urandom % 4) : SRC_REG;
    id_src2_sel_i = ($urandom % 2) ? SRC_REG : SRC_IMM;
    id_f3_i       = alu_f3_t'($urandom % 8);
    id_alt_i      = 1'($urandom % 2);
    id_branch_i   = 1'b0;
    id_jump_i     = 1'b0;
    id_lsu_op_i   = LSU_NONE;
    id_csr_op_i   = CSR_NONE;
    id_csr_addr_i = CSR_MSCRATCH;
    id_ecall_i    = 1'b0;
    id_mret_i     = 1'b0;
    if (k >= 60 && k < 68) begin
      id_branch_i = 1'b1;
      id_we_rd_i  = 1'b0;
      case ($urandom % 6)
        0: id_f3_i = F3_BEQ;
        1: id_f3_i = F3_BNE;
        2: id_f3_i = F3_BLT;
        3: id_f3_i = F3_BGE;
        4: id_f3_i = F3_BLTU;
        default: id_f3_i = F3_BGEU;
      endcase
      id_imm_i = target_offset();
    end else if (k >= 68 && k < 74) begin
      id_jump_i     = 1'b1;
      id_src1_sel_i = ($urandom % 4 == 0) ? SRC_REG : SRC_PC;
      id_imm_i      = target_offset();
    end else if (k >= 74 && k < 84) begin
      id_lsu_op_i   = ($urandom % 2) ? LSU_LOAD : LSU_STORE;
      id_we_rd_i    = 1'b0;
      id_src2_sel_i = SRC_IMM;
      id_f3_i       = F3_ADD_SUB;
      id_alt_i      = 1'b0;
    end else if (k >= 84 && k < 94) begin
      id_csr_op_i = csr_op_t'(1 + $urandom % 3);
      case ($urandom % 5)
        0: id_csr_addr_i = CSR_MTVEC;
        1: id_csr_addr_i = CSR_MEPC;
        2: id_csr_addr_i = CSR_MCAUSE;
        3: id_csr_addr_i = CSR_MSCRATCH;
        default: id_csr_addr_i = 12'h300;
      endcase
    end else if (k >= 94 && k < 97) begin
      id_ecall_i = 1'b1;
      id_we_rd_i = 1'b0;
    end else if (k >= 97) begin
      id_mret_i  = 1'b1;
      id_we_rd_i = 1'b0;
    end
  endtask

  task automatic check_cycle();
    logic acc;
    acc = id_valid_i && !lsu_bp_i;
    compare_value("id_ready", xlen_t'(!lsu_bp_i), xlen_t'(id_ready_o));
    compare_value("fetch_req", xlen_t'(exp_fetch_req), xlen_t'(fetch_req_o));
    if (exp_fetch_req) begin
      compare_value("fetch_addr", exp_fetch_addr, fetch_addr_o);
    end
    compare_value("wb_we", xlen_t'(exp_wb_we), xlen_t'(wb_we_o));
    if (exp_wb_we) begin
      compare_value("wb_rd", xlen_t'(exp_wb_rd), xlen_t'(wb_rd_o));
      compare_value("wb_data", exp_wb_data, wb_data_o);
    end
    model_step(acc);
    compare_value("lsu_op", xlen_t'(acc ? id_lsu_op_i : LSU_NONE), xlen_t'(lsu_op_o));
    if (acc && (id_lsu_op_i != LSU_NONE)) begin
      compare_value("lsu_addr", exp_lsu_addr, lsu_addr_o);
      compare_value("lsu_wdata", exp_lsu_wdata, lsu_wdata_o);
    end
  endtask

  initial begin
    int unsigned r;
    logic        done;
    logic        fresh;
    void'($urandom(SEED));
    clk   = 1'b0;
    rst_i = 1'b1;
    lsu_bp_i   = 1'b0;
    id_valid_i = 1'b0;
    gen_instr();
    model_reset();
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst_i = 1'b0;
    for (int n = 0; n < N_INSTR; n++) begin
      fresh = 1'b1;
      done  = 1'b0;
      while (!done) begin
        @(posedge clk);
        #1;
        if (fresh) begin
          gen_instr();
          fresh = 1'b0;
        end
        r = $urandom % 8;
        id_valid_i = (r != 0);
        lsu_bp_i   = (r == 1) || (r == 2);
        #8;
        check_cycle();
        done = id_valid_i && !lsu_bp_i;
      end
    end
    @(posedge clk);
    #1;
    id_valid_i = 1'b0;
    lsu_bp_i   = 1'b0;
    #8;
    check_cycle();
    $display("Test completed successfully");
    $finish;
  end

  // Each instruction averages under two cycles
  initial begin
    #((N_INSTR * 4 + RST_CYC + 2) * PERIOD);
    $display("Watchdog expired before all instructions were checked");
    $display("Test failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== dv/ex_asserts.sv ====
// Execute stage assertions
`timescale 1ns/1ns

module ex_asserts (
  input logic              clk,
  input logic              rst_i,
  input logic              lsu_bp_i,
  input logic              fetch_req_o,
  input logic              wb_we_o,
  input ex_pkg::reg_addr_t wb_rd_o,
  input ex_pkg::xlen_t     wb_data_o
);

  // Redirect is a single-cycle pulse
  a_fetch_pulse: assert property (@(posedge clk) disable iff (rst_i)
    fetch_req_o |=> !fetch_req_o)
    else $error("fetch_req_o high for two cycles");

  a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst_i)
    wb_we_o |-> (wb_rd_o != '0))
    else $error("writeback to x0");

  // Back-pressure freezes the result register
  a_wb_hold: assert property (@(posedge clk) disable iff (rst_i)
    lsu_bp_i |=> ($stable(wb_we_o) && $stable(wb_rd_o) && $stable(wb_data_o)))
    else $error("writeback changed under back-pressure");

endmodule

// ==== logic/ex_top.sv ====
// Execute stage with register file
`timescale 1ns/1ns

module ex_top #(
  parameter ex_pkg::xlen_t MTVEC_RESET = 32'h0000_1000
) (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              id_valid_i,
  output logic              id_ready_o,
  input  ex_pkg::xlen_t     id_pc_i,
  input  ex_pkg::xlen_t     id_imm_i,
  input  ex_pkg::reg_addr_t id_rs1_addr_i,
  input  ex_pkg::reg_addr_t id_rs2_addr_i,
  input  ex_pkg::reg_addr_t id_rd_addr_i,
  input  logic              id_we_rd_i,
  input  ex_pkg::src_sel_t  id_src1_sel_i,
  input  ex_pkg::src_sel_t  id_src2_sel_i,
  input  ex_pkg::alu_f3_t   id_f3_i,
  input  logic              id_alt_i,
  input  logic              id_branch_i,
  input  logic              id_jump_i,
  input  ex_pkg::lsu_op_t   id_lsu_op_i,
  input  ex_pkg::csr_op_t   id_csr_op_i,
  input  ex_pkg::csr_addr_t id_csr_addr_i,
  input  logic              id_ecall_i,
  input  logic              id_mret_i,
  input  logic              lsu_bp_i,
  output ex_pkg::lsu_op_t   lsu_op_o,
  output ex_pkg::xlen_t     lsu_addr_o,
  output ex_pkg::xlen_t     lsu_wdata_o,
  output logic              fetch_req_o,
  output ex_pkg::xlen_t     fetch_addr_o,
  output logic              wb_we_o,
  output ex_pkg::reg_addr_t wb_rd_o,
  output ex_pkg::xlen_t     wb_data_o
);
  import ex_pkg::*;

  xlen_t rs1_data;
  xlen_t rs2_data;

  // Written from the result register one cycle after accept
  reg_file u_rf (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (id_rs1_addr_i),
    .rs2_addr_i (id_rs2_addr_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_we_o),
    .rd_addr_i  (wb_rd_o),
    .rd_data_i  (wb_data_o)
  );

  exec_stage #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_exec (
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .*
  );

endmodule

// ==== logic/exec_stage.sv ====
// Execute stage
`timescale 1ns/1ns

module exec_stage #(
  parameter ex_pkg::xlen_t MTVEC_RESET = 32'h0000_1000
) (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              id_valid_i,
  output logic              id_ready_o,
  input  ex_pkg::xlen_t     id_pc_i,
  input  ex_pkg::xlen_t     id_imm_i,
  input  ex_pkg::reg_addr_t id_rs1_addr_i,
  input  ex_pkg::reg_addr_t id_rs2_addr_i,
  input  ex_pkg::reg_addr_t id_rd_addr_i,
  input  logic              id_we_rd_i,
  input  ex_pkg::src_sel_t  id_src1_sel_i,
  input  ex_pkg::src_sel_t  id_src2_sel_i,
  input  ex_pkg::alu_f3_t   id_f3_i,
  input  logic              id_alt_i,
  input  logic              id_branch_i,
  input  logic              id_jump_i,
  input  ex_pkg::lsu_op_t   id_lsu_op_i,
  input  ex_pkg::csr_op_t   id_csr_op_i,
  input  ex_pkg::csr_addr_t id_csr_addr_i,
  input  logic              id_ecall_i,
  input  logic              id_mret_i,
  input  ex_pkg::xlen_t     rs1_data_i,
  input  ex_pkg::xlen_t     rs2_data_i,
  input  logic              lsu_bp_i,
  output ex_pkg::lsu_op_t   lsu_op_o,
  output ex_pkg::xlen_t     lsu_addr_o,
  output ex_pkg::xlen_t     lsu_wdata_o,
  output logic              wb_we_o,
  output ex_pkg::reg_addr_t wb_rd_o,
  output ex_pkg::xlen_t     wb_data_o,
  output logic              fetch_req_o,
  output ex_pkg::xlen_t     fetch_addr_o
);
  import ex_pkg::*;

  logic  accept;
  logic  live;
  logic  fwd_rs1;
  logic  fwd_rs2;
  xlen_t rs1_val;
  xlen_t rs2_val;
  xlen_t op1;
  xlen_t op2;
  xlen_t alu_res;
  xlen_t jmp_sum;
  xlen_t target;
  logic  taken;
  logic  misaligned;
  logic  br_req_q;
  xlen_t br_addr_q;
  logic  csr_req;
  xlen_t csr_req_addr;
  xlen_t csr_rdata;
  xlen_t wb_data_d;

  function automatic logic branch_cond(alu_f3_t f3, xlen_t a, xlen_t b);
    logic t;
    case (f3)
      F3_BEQ:  t = (a == b);
      F3_BNE:  t = (a != b);
      F3_BLT:  t = ($signed(a) < $signed(b));
      F3_BGE:  t = ($signed(a) >= $signed(b));
      F3_BLTU: t = (a < b);
      F3_BGEU: t = (a >= b);
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  function automatic xlen_t src_mux(src_sel_t sel, xlen_t rval, xlen_t imm, xlen_t pc);
    xlen_t v;
    case (sel)
      SRC_REG: v = rval;
      SRC_IMM: v = imm;
      SRC_PC:  v = pc;
      default: v = '0;
    endcase
    return v;
  endfunction

  assign id_ready_o = ~lsu_bp_i;
  assign accept     = id_valid_i && id_ready_o;
  // Instructions behind a redirect are wrong-path
  assign live       = accept && !fetch_req_o;

  // Bypass the result register ahead of its register file write
  assign fwd_rs1 = wb_we_o && (wb_rd_o != '0) && (id_rs1_addr_i == wb_rd_o);
  assign fwd_rs2 = wb_we_o && (wb_rd_o != '0) && (id_rs2_addr_i == wb_rd_o);
  assign rs1_val = fwd_rs1 ? wb_data_o : rs1_data_i;
  assign rs2_val = fwd_rs2 ? wb_data_o : rs2_data_i;

  assign op1 = src_mux(id_src1_sel_i, rs1_val, id_imm_i, id_pc_i);
  assign op2 = src_mux(id_src2_sel_i, rs2_val, id_imm_i, id_pc_i);

  always_comb begin
    case (id_f3_i)
      F3_ADD_SUB: alu_res = id_alt_i ? (op1 - op2) : (op1 + op2);
      F3_SLL:     alu_res = op1 << op2[4:0];
      F3_SLT:     alu_res = xlen_t'($signed(op1) < $signed(op2));
      F3_SLTU:    alu_res = xlen_t'(op1 < op2);
      F3_XOR:     alu_res = op1 ^ op2;
      F3_SRL_SRA: alu_res = id_alt_i ? xlen_t'($signed(op1) >>> op2[4:0]) : (op1 >> op2[4:0]);
      F3_OR:      alu_res = op1 | op2;
      default:    alu_res = op1 & op2;
    endcase
  end

  // Jump base is rs1 or pc through the operand mux
  assign jmp_sum    = op1 + id_imm_i;
  assign target     = id_jump_i ? {jmp_sum[31:1], 1'b0} : (id_pc_i + id_imm_i);
  assign taken      = id_jump_i || (id_branch_i && branch_cond(id_f3_i, rs1_val, rs2_val));
  assign misaligned = taken && (target[1:0] != 2'b00);

  always_comb begin
    wb_data_d = alu_res;
    if (id_jump_i) begin
      wb_data_d = id_pc_i + 32'd4;
    end else if (id_csr_op_i != CSR_NONE) begin
      wb_data_d = csr_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_we_o   <= 1'b0;
      wb_rd_o   <= '0;
      wb_data_o <= '0;
      br_req_q  <= 1'b0;
      br_addr_q <= '0;
    end else begin
      br_req_q <= live && taken && !misaligned;
      if (!lsu_bp_i) begin
        wb_we_o   <= live && id_we_rd_i && (id_rd_addr_i != '0) && !misaligned && !id_ecall_i;
        wb_rd_o   <= id_rd_addr_i;
        wb_data_o <= wb_data_d;
        br_addr_q <= target;
      end
    end
  end

  assign lsu_op_o    = accept ? id_lsu_op_i : LSU_NONE;
  assign lsu_addr_o  = alu_res;
  assign lsu_wdata_o = rs2_val;

  csr_unit #(
    .MTVEC_RESET     (MTVEC_RESET)
  ) u_csr (
    .clk             (clk),
    .rst_i           (rst_i),
    .accept_i        (live),
    .csr_op_i        (id_csr_op_i),
    .csr_addr_i      (id_csr_addr_i),
    .csr_wdata_i     (rs1_val),
    .csr_rdata_o     (csr_rdata),
    .pc_i            (id_pc_i),
    .ecall_i         (id_ecall_i),
    .mret_i          (id_mret_i),
    .misaligned_i    (misaligned),
    .redirect_o      (csr_req),
    .redirect_addr_o (csr_req_addr)
  );

  // Trap and mret redirects take priority
  assign fetch_req_o  = csr_req || br_req_q;
  assign fetch_addr_o = csr_req ? csr_req_addr : br_addr_q;

endmodule

// ==== logic/csr_unit.sv ====
// Machine CSRs and trap control
`timescale 1ns/1ns

module csr_unit #(
  parameter ex_pkg::xlen_t MTVEC_RESET = 32'h0000_1000
) (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              accept_i,
  input  ex_pkg::csr_op_t   csr_op_i,
  input  ex_pkg::csr_addr_t csr_addr_i,
  input  ex_pkg::xlen_t     csr_wdata_i,
  output ex_pkg::xlen_t     csr_rdata_o,
  input  ex_pkg::xlen_t     pc_i,
  input  logic              ecall_i,
  input  logic              mret_i,
  input  logic              misaligned_i,
  output logic              redirect_o,
  output ex_pkg::xlen_t     redirect_addr_o
);
  import ex_pkg::*;

  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mscratch_q;
  xlen_t csr_new;
  logic  csr_hit;
  logic  csr_we;
  logic  trap;

  // Read side, unknown addresses read zero
  always_comb begin
    csr_hit     = 1'b1;
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MTVEC:    csr_rdata_o = mtvec_q;
      CSR_MEPC:     csr_rdata_o = mepc_q;
      CSR_MCAUSE:   csr_rdata_o = mcause_q;
      CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      default:      csr_hit = 1'b0;
    endcase
  end

  always_comb begin
    case (csr_op_i)
      CSR_RW:  csr_new = csr_wdata_i;
      CSR_RS:  csr_new = csr_rdata_o | csr_wdata_i;
      CSR_RC:  csr_new = csr_rdata_o & ~csr_wdata_i;
      default: csr_new = csr_rdata_o;
    endcase
  end

  assign trap   = accept_i && (ecall_i || misaligned_i);
  assign csr_we = accept_i && csr_hit && (csr_op_i != CSR_NONE);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mtvec_q    <= MTVEC_RESET;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mscratch_q <= '0;
    end else begin
      if (csr_we && (csr_addr_i == CSR_MTVEC)) begin
        mtvec_q <= csr_new;
      end
      if (csr_we && (csr_addr_i == CSR_MSCRATCH)) begin
        mscratch_q <= csr_new;
      end
      // Trap entry wins over a software write
      if (trap) begin
        mepc_q   <= pc_i;
        mcause_q <= ecall_i ? CAUSE_ECALL_M : CAUSE_MISALIGNED_FETCH;
      end else begin
        if (csr_we && (csr_addr_i == CSR_MEPC)) begin
          mepc_q <= csr_new;
        end
        if (csr_we && (csr_addr_i == CSR_MCAUSE)) begin
          mcause_q <= csr_new;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      redirect_o      <= 1'b0;
      redirect_addr_o <= '0;
    end else begin
      redirect_o      <= trap || (accept_i && mret_i);
      redirect_addr_o <= trap ? mtvec_q : mepc_q;
    end
  end

endmodule

// ==== logic/reg_file.sv ====
// Integer register file
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              rst_i,
  input  ex_pkg::reg_addr_t rs1_addr_i,
  input  ex_pkg::reg_addr_t rs2_addr_i,
  output ex_pkg::xlen_t     rs1_data_o,
  output ex_pkg::xlen_t     rs2_data_o,
  input  logic              we_i,
  input  ex_pkg::reg_addr_t rd_addr_i,
  input  ex_pkg::xlen_t     rd_data_i
);
  import ex_pkg::*;

  // x0 has no storage
  xlen_t regs_q [1:31];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  always_comb begin
    rs1_data_o = '0;
    rs2_data_o = '0;
    if (rs1_addr_i != '0) begin
      rs1_data_o = regs_q[rs1_addr_i];
    end
    if (rs2_addr_i != '0) begin
      rs2_data_o = regs_q[rs2_addr_i];
    end
  end

endmodule

// ==== logic/ex_pkg.sv ====
// Execute stage shared definitions
package ex_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [1:0]      src_sel_t;
  typedef logic [2:0]      alu_f3_t;
  typedef logic [1:0]      lsu_op_t;
  typedef logic [1:0]      csr_op_t;
  typedef logic [11:0]     csr_addr_t;

  // Operand sources
  localparam src_sel_t SRC_REG  = 2'd0;
  localparam src_sel_t SRC_IMM  = 2'd1;
  localparam src_sel_t SRC_ZERO = 2'd2;
  localparam src_sel_t SRC_PC   = 2'd3;

  // ALU funct3
  localparam alu_f3_t F3_ADD_SUB = 3'b000;
  localparam alu_f3_t F3_SLL     = 3'b001;
  localparam alu_f3_t F3_SLT     = 3'b010;
  localparam alu_f3_t F3_SLTU    = 3'b011;
  localparam alu_f3_t F3_XOR     = 3'b100;
  localparam alu_f3_t F3_SRL_SRA = 3'b101;
  localparam alu_f3_t F3_OR      = 3'b110;
  localparam alu_f3_t F3_AND     = 3'b111;

  // Branch conditions, same field
  localparam alu_f3_t F3_BEQ  = 3'b000;
  localparam alu_f3_t F3_BNE  = 3'b001;
  localparam alu_f3_t F3_BLT  = 3'b100;
  localparam alu_f3_t F3_BGE  = 3'b101;
  localparam alu_f3_t F3_BLTU = 3'b110;
  localparam alu_f3_t F3_BGEU = 3'b111;

  localparam lsu_op_t LSU_NONE  = 2'd0;
  localparam lsu_op_t LSU_LOAD  = 2'd1;
  localparam lsu_op_t LSU_STORE = 2'd2;

  localparam csr_op_t CSR_NONE = 2'd0;
  localparam csr_op_t CSR_RW   = 2'd1;
  localparam csr_op_t CSR_RS   = 2'd2;
  localparam csr_op_t CSR_RC   = 2'd3;

  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  localparam xlen_t CAUSE_MISALIGNED_FETCH = 32'd0;
  localparam xlen_t CAUSE_ECALL_M          = 32'd11;

endpackage
